// File: stq_params.svh
`ifndef STQ_PARAMS_SVH
`define STQ_PARAMS_SVH

// Queue geometry
`define STQ_DEPTH      16
`define STQ_IDX_W      4

// Address and data widths
`define STQ_ADDR_W     16
`define STQ_DATA_W     32
`define STQ_BYTES      4   // Lanes per data word

// Load-check ports searched each cycle
`define STQ_CHK_PORTS  2

`endif

// File: stq_pkg.sv
`include "stq_params.svh"

package stq_pkg;

  typedef logic [`STQ_IDX_W-1:0]  stq_idx_t;
  typedef logic [`STQ_ADDR_W-1:0] stq_addr_t;
  typedef logic [`STQ_DATA_W-1:0] stq_word_t;   // Lane aligned
  typedef logic [`STQ_BYTES-1:0]  stq_mask_t;

  typedef enum logic [1:0] {
    sz_byte = 2'd0,
    sz_half = 2'd1,
    sz_word = 2'd2
  } stq_size_e;

  // Accesses are naturally aligned, so a half never straddles lanes 1 and 2
  function automatic stq_mask_t stq_byte_mask(stq_size_e size, logic [1:0] low);
    case (size)
      sz_byte: return stq_mask_t'(1) << low;
      sz_half: return low[1] ? (stq_mask_t'(3) << 2) : stq_mask_t'(3);
      default: return '1;
    endcase
  endfunction

endpackage

// File: stq_fwd_if.sv
`timescale 1ns/1ps
`include "stq_params.svh"

interface stq_fwd_if;
  stq_pkg::stq_idx_t  hit_idx;     // Youngest overlapping entry
  logic               overlap;
  logic               covered;     // Entry bytes contain the load bytes
  logic               has_data;
  stq_pkg::stq_mask_t load_mask;

  modport array (
    output hit_idx, overlap, covered, has_data, load_mask
  );

  modport fwd (
    input hit_idx, overlap, covered, has_data, load_mask
  );
endinterface

// File: stq_drain_if.sv
`timescale 1ns/1ps
`include "stq_params.svh"

interface stq_drain_if;
  stq_pkg::stq_idx_t  head_idx;
  logic               head_ready;  // Valid, committed, data present
  stq_pkg::stq_addr_t head_addr;
  stq_pkg::stq_mask_t head_mask;
  logic               pop;

  modport array (
    output head_idx, head_ready, head_addr, head_mask,
    input  pop
  );

  modport drain (
    input  head_idx, head_ready, head_addr, head_mask,
    output pop
  );
endinterface

// File: stq_entry_array.sv
`timescale 1ns/1ps
`include "stq_params.svh"

module stq_entry_array (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      alloc_en,
  input  stq_pkg::stq_addr_t        alloc_addr,
  input  stq_pkg::stq_size_e        alloc_size,
  output stq_pkg::stq_idx_t         alloc_idx,
  output logic                      full,
  input  logic                      upd_en,
  input  stq_pkg::stq_idx_t         upd_idx,
  input  logic                      pse_en,
  input  stq_pkg::stq_idx_t         pse_idx,
  input  logic                      excpt,
  input  logic [`STQ_CHK_PORTS-1:0] chk_en,
  input  stq_pkg::stq_addr_t        chk_addr [`STQ_CHK_PORTS],
  input  stq_pkg::stq_size_e        chk_size [`STQ_CHK_PORTS],
  stq_fwd_if.array                  fwd [`STQ_CHK_PORTS],
  stq_drain_if.array                drain
);

  logic [`STQ_DEPTH-1:0] valid;
  logic [`STQ_DEPTH-1:0] committed;
  logic [`STQ_DEPTH-1:0] has_data;
  stq_pkg::stq_addr_t    addr_q [`STQ_DEPTH];
  stq_pkg::stq_mask_t    mask_q [`STQ_DEPTH];
  stq_pkg::stq_idx_t     head;
  stq_pkg::stq_idx_t     tail;
  logic [`STQ_IDX_W:0]   count;
  logic [`STQ_DEPTH-1:0] keep;
  logic [`STQ_DEPTH-1:0] pop_vec;
  logic [`STQ_IDX_W:0]   n_keep;
  logic [`STQ_IDX_W:0]   alloc_inc;
  logic [`STQ_IDX_W:0]   pop_dec;

  assign alloc_idx = tail;
  assign full      = count[`STQ_IDX_W];   // Count tops out at depth
  assign alloc_inc = {{`STQ_IDX_W{1'b0}}, alloc_en};
  assign pop_dec   = {{`STQ_IDX_W{1'b0}}, drain.pop};

  // Entries surviving an exception; passe is in order so these sit right after head
  always_comb begin
    keep = valid & committed;
    if (pse_en)
      keep[pse_idx] = valid[pse_idx];
    n_keep = '0;
    for (int i = 0; i < `STQ_DEPTH; i++)
      n_keep = n_keep + {{`STQ_IDX_W{1'b0}}, keep[i]};
    pop_vec = '0;
    if (drain.pop)
      pop_vec[head] = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid     <= '0;
      committed <= '0;
      has_data  <= '0;
      head      <= '0;
      tail      <= '0;
      count     <= '0;
    end else begin
      if (upd_en)
        has_data[upd_idx] <= 1'b1;
      if (pse_en)
        committed[pse_idx] <= 1'b1;
      if (drain.pop)
        head <= head + 1'b1;
      if (excpt) begin
        valid <= keep & ~pop_vec;
        tail  <= head + n_keep[`STQ_IDX_W-1:0];   // Rewind past the flushed stores
        count <= n_keep - pop_dec;
      end else begin
        if (alloc_en) begin
          valid[tail]     <= 1'b1;
          committed[tail] <= 1'b0;
          has_data[tail]  <= 1'b0;
          tail            <= tail + 1'b1;
        end
        if (drain.pop)
          valid[head] <= 1'b0;
        count <= count + alloc_inc - pop_dec;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (alloc_en) begin
      addr_q[tail] <= alloc_addr;
      mask_q[tail] <= stq_pkg::stq_byte_mask(alloc_size, alloc_addr[1:0]);
    end
  end

  for (genvar p = 0; p < `STQ_CHK_PORTS; p++) begin : g_chk
    stq_pkg::stq_mask_t    ld_mask;
    logic [`STQ_DEPTH-1:0] match;
    stq_pkg::stq_idx_t     sel;
    logic                  found;

    assign ld_mask = stq_pkg::stq_byte_mask(chk_size[p], chk_addr[p][1:0]);

    always_comb begin
      for (int i = 0; i < `STQ_DEPTH; i++)
        match[i] = valid[i] && |(mask_q[i] & ld_mask) &&
                   (addr_q[i][`STQ_ADDR_W-1:2] == chk_addr[p][`STQ_ADDR_W-1:2]);
    end

    // Walk back from the tail, first hit is the youngest store
    always_comb begin
      stq_pkg::stq_idx_t idx;
      found = 1'b0;
      sel   = '0;
      for (int k = 0; k < `STQ_DEPTH; k++) begin
        idx = tail - stq_pkg::stq_idx_t'(k + 1);
        if (!found && match[idx]) begin
          found = 1'b1;
          sel   = idx;
        end
      end
    end

    assign fwd[p].hit_idx   = sel;
    assign fwd[p].overlap   = chk_en[p] && found;
    assign fwd[p].covered   = (mask_q[sel] & ld_mask) == ld_mask;
    assign fwd[p].has_data  = has_data[sel];
    assign fwd[p].load_mask = ld_mask;
  end

  assign drain.head_idx   = head;
  assign drain.head_ready = valid[head] && committed[head] && has_data[head];
  assign drain.head_addr  = addr_q[head];
  assign drain.head_mask  = mask_q[head];

  a_no_alloc_full: assert property (@(posedge clk) disable iff (!rst_n)
    alloc_en |-> !full);
  a_upd_live: assert property (@(posedge clk) disable iff (!rst_n)
    upd_en |-> valid[upd_idx]);
  a_pse_live: assert property (@(posedge clk) disable iff (!rst_n)
    pse_en |-> valid[pse_idx]);

endmodule

// File: stq_data_array.sv
`timescale 1ns/1ps
`include "stq_params.svh"

module stq_data_array (
  input  logic               clk,
  input  logic               upd_en,
  input  stq_pkg::stq_idx_t  upd_idx,
  input  stq_pkg::stq_word_t upd_data,
  input  stq_pkg::stq_idx_t  rd_idx  [`STQ_CHK_PORTS+1],
  output stq_pkg::stq_word_t rd_data [`STQ_CHK_PORTS+1]
);

  // One word per entry, lanes already aligned to the address
  stq_pkg::stq_word_t mem [`STQ_DEPTH];

  always_ff @(posedge clk) begin
    if (upd_en)
      mem[upd_idx] <= upd_data;
  end

  // Check ports first, drain port last
  for (genvar r = 0; r < `STQ_CHK_PORTS + 1; r++) begin : g_rd
    assign rd_data[r] = mem[rd_idx[r]];
  end

endmodule

// File: stq_fwd_stage.sv
`timescale 1ns/1ps
`include "stq_params.svh"

module stq_fwd_stage (
  input  logic                      clk,
  input  logic                      rst_n,
  stq_fwd_if.fwd                    fwd [`STQ_CHK_PORTS],
  input  logic [`STQ_CHK_PORTS-1:0] chk_en,
  input  stq_pkg::stq_word_t        entry_data [`STQ_CHK_PORTS],
  output logic [`STQ_CHK_PORTS-1:0] chk_valid,
  output logic [`STQ_CHK_PORTS-1:0] chk_hit,
  output logic [`STQ_CHK_PORTS-1:0] chk_partial,
  output stq_pkg::stq_word_t        chk_data [`STQ_CHK_PORTS]
);

  logic [`STQ_CHK_PORTS-1:0] hit_v;
  logic [`STQ_CHK_PORTS-1:0] partial_v;
  stq_pkg::stq_word_t        data_v [`STQ_CHK_PORTS];

  for (genvar p = 0; p < `STQ_CHK_PORTS; p++) begin : g_port
    stq_pkg::stq_word_t lane_mask;

    for (genvar b = 0; b < `STQ_BYTES; b++) begin : g_lane
      assign lane_mask[8*b +: 8] = {8{fwd[p].load_mask[b]}};
    end

    assign hit_v[p]     = fwd[p].overlap && fwd[p].covered && fwd[p].has_data;
    assign partial_v[p] = fwd[p].overlap && !hit_v[p];   // Short overlap or data still missing
    assign data_v[p]    = hit_v[p] ? (entry_data[p] & lane_mask) : '0;

    a_hit_excl: assert property (@(posedge clk) disable iff (!rst_n)
      (chk_hit[p] || chk_partial[p]) |-> (chk_valid[p] && !(chk_hit[p] && chk_partial[p])));
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      chk_valid   <= '0;
      chk_hit     <= '0;
      chk_partial <= '0;
    end else begin
      chk_valid   <= chk_en;
      chk_hit     <= hit_v;
      chk_partial <= partial_v;
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < `STQ_CHK_PORTS; p++)
      chk_data[p] <= data_v[p];
  end

endmodule

// File: stq_drain.sv
`timescale 1ns/1ps
`include "stq_params.svh"

module stq_drain (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               stall,
  stq_drain_if.drain         drain,
  input  stq_pkg::stq_word_t head_data,
  output logic               wb_en,
  output stq_pkg::stq_addr_t wb_addr,
  output stq_pkg::stq_word_t wb_data,
  output stq_pkg::stq_mask_t wb_mask
);

  logic pop;

  assign pop       = drain.head_ready && !stall;   // Stall is the only back-pressure
  assign drain.pop = pop;

  always_ff @(posedge clk) begin
    if (!rst_n)
      wb_en <= 1'b0;
    else
      wb_en <= pop;
  end

  // Capture the head as it leaves the queue
  always_ff @(posedge clk) begin
    if (pop) begin
      wb_addr <= drain.head_addr;
      wb_data <= head_data;
      wb_mask <= drain.head_mask;
    end
  end

  a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    stall |=> !wb_en);

endmodule

// File: stq.sv
`timescale 1ns/1ps
`include "stq_params.svh"

module stq (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      alloc_en,
  input  stq_pkg::stq_addr_t        alloc_addr,
  input  stq_pkg::stq_size_e        alloc_size,
  output stq_pkg::stq_idx_t         alloc_idx,
  output logic                      full,
  input  logic                      upd_en,
  input  stq_pkg::stq_idx_t         upd_idx,
  input  stq_pkg::stq_word_t        upd_data,
  input  logic                      pse_en,
  input  stq_pkg::stq_idx_t         pse_idx,
  input  logic                      excpt,
  input  logic                      stall,
  input  logic [`STQ_CHK_PORTS-1:0] chk_en,
  input  stq_pkg::stq_addr_t        chk_addr [`STQ_CHK_PORTS],
  input  stq_pkg::stq_size_e        chk_size [`STQ_CHK_PORTS],
  output logic [`STQ_CHK_PORTS-1:0] chk_valid,
  output logic [`STQ_CHK_PORTS-1:0] chk_hit,
  output logic [`STQ_CHK_PORTS-1:0] chk_partial,
  output stq_pkg::stq_word_t        chk_data [`STQ_CHK_PORTS],
  output logic                      wb_en,
  output stq_pkg::stq_addr_t        wb_addr,
  output stq_pkg::stq_word_t        wb_data,
  output stq_pkg::stq_mask_t        wb_mask
);

  stq_pkg::stq_idx_t  rd_idx  [`STQ_CHK_PORTS+1];
  stq_pkg::stq_word_t rd_data [`STQ_CHK_PORTS+1];
  stq_pkg::stq_word_t entry_data [`STQ_CHK_PORTS];

  stq_fwd_if   fwd_if [`STQ_CHK_PORTS] ();
  stq_drain_if drain_if_i ();

  for (genvar p = 0; p < `STQ_CHK_PORTS; p++) begin : g_rd
    assign rd_idx[p]     = fwd_if[p].hit_idx;
    assign entry_data[p] = rd_data[p];
  end
  assign rd_idx[`STQ_CHK_PORTS] = drain_if_i.head_idx;   // Last read port feeds writeback

  stq_entry_array entry_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .alloc_en   (alloc_en),
    .alloc_addr (alloc_addr),
    .alloc_size (alloc_size),
    .alloc_idx  (alloc_idx),
    .full       (full),
    .upd_en     (upd_en),
    .upd_idx    (upd_idx),
    .pse_en     (pse_en),
    .pse_idx    (pse_idx),
    .excpt      (excpt),
    .chk_en     (chk_en),
    .chk_addr   (chk_addr),
    .chk_size   (chk_size),
    .fwd        (fwd_if),
    .drain      (drain_if_i)
  );

  stq_data_array data_i (
    .clk      (clk),
    .upd_en   (upd_en),
    .upd_idx  (upd_idx),
    .upd_data (upd_data),
    .rd_idx   (rd_idx),
    .rd_data  (rd_data)
  );

  stq_fwd_stage fwd_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .fwd         (fwd_if),
    .chk_en      (chk_en),
    .entry_data  (entry_data),
    .chk_valid   (chk_valid),
    .chk_hit     (chk_hit),
    .chk_partial (chk_partial),
    .chk_data    (chk_data)
  );

  stq_drain drain_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .stall     (stall),
    .drain     (drain_if_i),
    .head_data (rd_data[`STQ_CHK_PORTS]),
    .wb_en     (wb_en),
    .wb_addr   (wb_addr),
    .wb_data   (wb_data),
    .wb_mask   (wb_mask)
  );

endmodule

// File: stq_checker.sv
`timescale 1ns/1ps
`include "stq_params.svh"

module stq_checker (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      alloc_en,
  input  stq_pkg::stq_addr_t        alloc_addr,
  input  stq_pkg::stq_size_e        alloc_size,
  input  stq_pkg::stq_idx_t         alloc_idx,
  input  logic                      full,
  input  logic                      upd_en,
  input  stq_pkg::stq_idx_t         upd_idx,
  input  stq_pkg::stq_word_t        upd_data,
  input  logic                      pse_en,
  input  stq_pkg::stq_idx_t         pse_idx,
  input  logic                      excpt,
  input  logic                      stall,
  input  logic [`STQ_CHK_PORTS-1:0] chk_en,
  input  stq_pkg::stq_addr_t        chk_addr [`STQ_CHK_PORTS],
  input  stq_pkg::stq_size_e        chk_size [`STQ_CHK_PORTS],
  input  logic [`STQ_CHK_PORTS-1:0] chk_valid,
  input  logic [`STQ_CHK_PORTS-1:0] chk_hit,
  input  logic [`STQ_CHK_PORTS-1:0] chk_partial,
  input  stq_pkg::stq_word_t        chk_data [`STQ_CHK_PORTS],
  input  logic                      wb_en,
  input  stq_pkg::stq_addr_t        wb_addr,
  input  stq_pkg::stq_word_t        wb_data,
  input  stq_pkg::stq_mask_t        wb_mask,
  output stq_pkg::stq_idx_t         head,
  output logic [`STQ_IDX_W:0]       count,
  output logic [`STQ_IDX_W:0]       n_comm,   // Committed prefix of the live stores
  output int                        errors
);

  logic [`STQ_DEPTH-1:0]     m_comm;
  logic [`STQ_DEPTH-1:0]     m_hasd;
  stq_pkg::stq_addr_t        m_addr [`STQ_DEPTH];
  stq_pkg::stq_mask_t        m_mask [`STQ_DEPTH];
  stq_pkg::stq_word_t        m_data [`STQ_DEPTH];
  stq_pkg::stq_idx_t         tail;
  logic [`STQ_CHK_PORTS-1:0] e_valid;
  logic [`STQ_CHK_PORTS-1:0] e_hit;
  logic [`STQ_CHK_PORTS-1:0] e_partial;
  stq_pkg::stq_word_t        e_data [`STQ_CHK_PORTS];
  logic                      e_wb;
  stq_pkg::stq_addr_t        e_wb_addr;
  stq_pkg::stq_word_t        e_wb_data;
  stq_pkg::stq_mask_t        e_wb_mask;

  // An access of 2**size bytes starts at a multiple of its own size
  function automatic stq_pkg::stq_mask_t lanes(stq_pkg::stq_size_e size, stq_pkg::stq_addr_t a);
    int                 len;
    int                 first;
    stq_pkg::stq_mask_t m;
    len   = 1 << int'(size);
    first = (int'(a[1:0]) / len) * len;
    for (int b = 0; b < `STQ_BYTES; b++)
      m[b] = (b >= first) && (b < first + len);
    return m;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors = errors + 1;
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic predict_check(input int p);
    stq_pkg::stq_mask_t lm;
    stq_pkg::stq_idx_t  i;
    stq_pkg::stq_idx_t  sel;
    logic               found;
    lm    = lanes(chk_size[p], chk_addr[p]);
    found = 1'b0;
    sel   = '0;
    for (int k = 0; k < int'(count); k++) begin   // Oldest to youngest so the last match wins
      i = head + stq_pkg::stq_idx_t'(k);
      if (m_addr[i][`STQ_ADDR_W-1:2] == chk_addr[p][`STQ_ADDR_W-1:2] &&
          (m_mask[i] & lm) != '0) begin
        found = 1'b1;
        sel   = i;
      end
    end
    e_valid[p]   = chk_en[p];
    e_hit[p]     = chk_en[p] && found && ((m_mask[sel] & lm) == lm) && m_hasd[sel];
    e_partial[p] = chk_en[p] && found && !e_hit[p];
    e_data[p]    = '0;
    for (int b = 0; b < `STQ_BYTES; b++)
      if (e_hit[p] && lm[b])
        e_data[p][8*b +: 8] = m_data[sel][8*b +: 8];
  endtask

  task automatic advance_model();
    if (upd_en) begin
      m_data[upd_idx] = upd_data;
      m_hasd[upd_idx] = 1'b1;
    end
    if (pse_en) begin
      m_comm[pse_idx] = 1'b1;
      n_comm          = n_comm + 1'b1;
    end
    if (e_wb) begin
      head   = head + 1'b1;
      count  = count - 1'b1;
      n_comm = n_comm - 1'b1;
    end
    if (excpt) begin
      count = n_comm;
      tail  = head + n_comm[`STQ_IDX_W-1:0];
    end else if (alloc_en) begin
      m_addr[tail] = alloc_addr;
      m_mask[tail] = lanes(alloc_size, alloc_addr);
      m_comm[tail] = 1'b0;
      m_hasd[tail] = 1'b0;
      tail         = tail + 1'b1;
      count        = count + 1'b1;
    end
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      head      = '0;
      tail      = '0;
      count     = '0;
      n_comm    = '0;
      m_comm    = '0;
      m_hasd    = '0;
      e_valid   = '0;
      e_hit     = '0;
      e_partial = '0;
      for (int p = 0; p < `STQ_CHK_PORTS; p++)
        e_data[p] = '0;
      e_wb      = 1'b0;
      errors    = 0;
    end else begin
      compare_value("alloc_idx", tail, alloc_idx);
      compare_value("full", count == `STQ_DEPTH, full);
      compare_value("wb_en", e_wb, wb_en);
      if (e_wb) begin
        compare_value("wb_addr", e_wb_addr, wb_addr);
        compare_value("wb_data", e_wb_data, wb_data);
        compare_value("wb_mask", e_wb_mask, wb_mask);
      end
      for (int p = 0; p < `STQ_CHK_PORTS; p++) begin
        compare_value($sformatf("chk_valid[%0d]", p), e_valid[p], chk_valid[p]);
        compare_value($sformatf("chk_hit[%0d]", p), e_hit[p], chk_hit[p]);
        compare_value($sformatf("chk_partial[%0d]", p), e_partial[p], chk_partial[p]);
        compare_value($sformatf("chk_data[%0d]", p), e_data[p], chk_data[p]);
        predict_check(p);
      end
      e_wb      = (count != 0) && m_comm[head] && m_hasd[head] && !stall;
      e_wb_addr = m_addr[head];
      e_wb_data = m_data[head];
      e_wb_mask = m_mask[head];
      advance_model();
    end
  end

endmodule

// File: tb_stq.sv
`timescale 1ns/1ps
`include "stq_params.svh"

module tb_stq #(
  parameter logic [31:0] lcg_seed = 32'h0ac5_cce3
);

  localparam int n_cycles   = 3000;
  localparam int clk_period = 4;
  localparam int rst_cycles = 3;
  localparam int drive_dly  = 1;
  localparam int limit_ns   = n_cycles * clk_period * 2;

  logic                      clk;
  logic                      rst_n;
  logic                      alloc_en;
  logic                      full;
  logic                      upd_en;
  logic                      pse_en;
  logic                      excpt;
  logic                      stall;
  logic                      wb_en;
  stq_pkg::stq_addr_t        alloc_addr;
  stq_pkg::stq_addr_t        wb_addr;
  stq_pkg::stq_size_e        alloc_size;
  stq_pkg::stq_idx_t         alloc_idx;
  stq_pkg::stq_idx_t         upd_idx;
  stq_pkg::stq_idx_t         pse_idx;
  stq_pkg::stq_idx_t         head;
  stq_pkg::stq_word_t        upd_data;
  stq_pkg::stq_word_t        wb_data;
  stq_pkg::stq_mask_t        wb_mask;
  logic [`STQ_CHK_PORTS-1:0] chk_en;
  logic [`STQ_CHK_PORTS-1:0] chk_valid;
  logic [`STQ_CHK_PORTS-1:0] chk_hit;
  logic [`STQ_CHK_PORTS-1:0] chk_partial;
  stq_pkg::stq_addr_t        chk_addr [`STQ_CHK_PORTS];
  stq_pkg::stq_size_e        chk_size [`STQ_CHK_PORTS];
  stq_pkg::stq_word_t        chk_data [`STQ_CHK_PORTS];
  logic [`STQ_IDX_W:0]       count;    // Model state read back for stimulus
  logic [`STQ_IDX_W:0]       n_comm;
  int                        errors;
  logic [31:0]               rng;

  stq stq_i (.*);

  stq_checker model_i (.*);

  initial clk = 1'b0;
  always #(clk_period / 2) clk = ~clk;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic draw(input int n, output int r);
    rng = lcg_step(rng);
    r   = int'(rng[31:16]) % n;   // High bits have the longer period
  endtask

  // Eight words so that stores and loads collide often
  task automatic pick_access(output stq_pkg::stq_addr_t a, output stq_pkg::stq_size_e sz);
    int w;
    int s;
    int low;
    draw(8, w);
    draw(3, s);
    draw(4, low);
    sz  = stq_pkg::stq_size_e'(s);
    low = low & ~((1 << s) - 1);
    a   = 16'h1200 + stq_pkg::stq_addr_t'(w * 4 + low);
  endtask

  task automatic drive_cycle(input logic active);
    int r;
    int off;
    draw(100, r);
    stall = (r < 30);
    draw(100, r);
    excpt = active && (r < 2);
    draw(2, r);
    alloc_en = active && !excpt && (count < `STQ_DEPTH) && (r == 1);
    pick_access(alloc_addr, alloc_size);
    draw(2, r);
    upd_en = active && (count != 0) && (r == 1);
    draw(`STQ_DEPTH, off);
    if (count != 0)
      off = off % int'(count);
    upd_idx  = active ? head + stq_pkg::stq_idx_t'(off) : '0;
    upd_data = rng;
    draw(5, r);
    pse_en  = active && (n_comm < count) && (r < 2);
    pse_idx = active ? head + n_comm[`STQ_IDX_W-1:0] : '0;   // Oldest uncommitted store
    for (int p = 0; p < `STQ_CHK_PORTS; p++) begin
      draw(2, r);
      chk_en[p] = active && (r == 1);
      pick_access(chk_addr[p], chk_size[p]);
    end
  endtask

  initial begin
    rng   = lcg_seed;
    rst_n = 1'b0;
    drive_cycle(1'b0);
    repeat (rst_cycles) @(posedge clk);
    #(drive_dly) rst_n = 1'b1;
    repeat (4) @(posedge clk);
    for (int c = 0; c < n_cycles; c++) begin
      @(posedge clk);
      #(drive_dly) drive_cycle(1'b1);
    end
    @(posedge clk);
    #(drive_dly) drive_cycle(1'b0);
    repeat (3) @(posedge clk);
    #(drive_dly);
    $display("store queue run done, %0d errors", errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

  initial begin
    #(limit_ns);
    $display("Watchdog expired after %0d ns, the run did not complete", limit_ns);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+.
stq_pkg.sv
stq_fwd_if.sv
stq_drain_if.sv
stq_entry_array.sv
stq_data_array.sv
stq_fwd_stage.sv
stq_drain.sv
stq.sv
stq_checker.sv
tb_stq.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_stq
SEED      ?= 180735203
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FLIST     ?= verilog.f
VFLAGS    ?= --binary --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Glcg_seed=$(SEED) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "TESTS PASSED" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
